//--- hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// integer register width for RV64I
`define RV_XLEN 64

// architectural register file
`define RV_REG_COUNT 32
`define RV_REG_ADDR_W 5

`endif

//--- hw/rvIsaPkg.sv
`default_nettype none

`include "rv_config.svh"

package rvIsaPkg;

    typedef logic [31:0] instT;                     // raw 32-bit encoding
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;
    typedef logic [`RV_REG_ADDR_W-1:0] regAddrT;

    // major opcodes the core executes, all others decode as illegal
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111
    } opcodeT;

    localparam funct3T F3_ADD  = 3'b000;            // add, sub, addi, addw
    localparam funct3T F3_SLL  = 3'b001;
    localparam funct3T F3_SLT  = 3'b010;
    localparam funct3T F3_SLTU = 3'b011;
    localparam funct3T F3_XOR  = 3'b100;
    localparam funct3T F3_SR   = 3'b101;            // srl and sra share funct3
    localparam funct3T F3_OR   = 3'b110;
    localparam funct3T F3_AND  = 3'b111;

    localparam funct7T F7_BASE = 7'b0000000;
    localparam funct7T F7_ALT  = 7'b0100000;        // selects sub / sra

endpackage

`default_nettype wire

//--- hw/rvCtrlPkg.sv
`default_nettype none

`include "rv_config.svh"

package rvCtrlPkg;

    typedef logic [`RV_XLEN-1:0] xlenT;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB                                       // lui result
    } aluOpT;

    typedef enum logic [1:0] {
        SEL_A_REG,
        SEL_A_PC,                                   // auipc
        SEL_A_ZERO
    } selAT;

    typedef enum logic {
        SEL_B_REG,
        SEL_B_IMM
    } selBT;

    // everything the execute stage needs, operands already resolved
    typedef struct packed {
        logic              valid;
        logic              illegal;
        logic              writeRd;
        rvIsaPkg::regAddrT rd;
        aluOpT             aluOp;
        logic              word;                    // truncate and sign-extend result
        logic              wordShiftSigned;         // sraw / sraiw
        logic              wordShiftUnsigned;       // srlw / srliw
        xlenT              operandA;
        xlenT              operandB;
    } decodedT;

    typedef struct packed {
        logic              valid;
        logic              illegal;
        rvIsaPkg::regAddrT rd;
        xlenT              data;
    } wbT;

endpackage

`default_nettype wire

//--- hw/regFile.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_config.svh"

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  rvIsaPkg::regAddrT rs1,
    input  rvIsaPkg::regAddrT rs2,
    output rvCtrlPkg::xlenT   rs1Data,
    output rvCtrlPkg::xlenT   rs2Data,
    input  rvCtrlPkg::wbT     wb
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // x0 stays zero since decode never sets writeRd for rd 0
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1Data = regs[rs1];                     // async read, bypass sits in decode
    assign rs2Data = regs[rs2];

    noWriteToZero: assert property (@(posedge clk) disable iff (!arstN)
        wb.valid |-> wb.rd != '0);

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_config.svh"

module decodeStage (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instValid,
    input  rvIsaPkg::instT     inst,
    input  rvCtrlPkg::xlenT    pc,
    output rvIsaPkg::regAddrT  rs1,
    output rvIsaPkg::regAddrT  rs2,
    input  rvCtrlPkg::xlenT    rs1Data,
    input  rvCtrlPkg::xlenT    rs2Data,
    input  rvCtrlPkg::wbT      exFwd,
    input  rvCtrlPkg::wbT      wbFwd,
    output rvCtrlPkg::decodedT exStage
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    opcodeT  opcode;
    funct3T  funct3;
    funct7T  funct7;
    regAddrT rd;
    xlenT    immI;
    xlenT    immU;
    xlenT    imm;
    xlenT    rs1Val;
    xlenT    rs2Val;
    aluOpT   aluOp;
    selAT    selA;
    selBT    selB;
    logic    illegalDec;
    logic    word;
    decodedT nextStage;

    // alt picks sub over add and sra over srl
    function automatic aluOpT mapAluOp(funct3T f3, logic alt);
        case (f3)
            F3_ADD:  return alt ? SUB : ADD;
            F3_SLL:  return SLL;
            F3_SLT:  return SLT;
            F3_SLTU: return SLTU;
            F3_XOR:  return XOR;
            F3_SR:   return alt ? SRA : SRL;
            F3_OR:   return OR;
            F3_AND:  return AND;
            default: return ADD;
        endcase
    endfunction

    // youngest producer wins
    function automatic xlenT bypass(regAddrT addr, xlenT rfData, wbT ex, wbT late);
        if (ex.valid && ex.rd == addr) begin
            return ex.data;
        end
        if (late.valid && late.rd == addr) begin
            return late.data;
        end
        return rfData;
    endfunction

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    assign immI = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
    assign immU = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};

    assign rs1Val = bypass(rs1, rs1Data, exFwd, wbFwd);
    assign rs2Val = bypass(rs2, rs2Data, exFwd, wbFwd);

    always_comb begin
        illegalDec = 1'b0;
        aluOp      = ADD;
        selA       = SEL_A_REG;
        selB       = SEL_B_REG;
        imm        = immI;
        word       = 1'b0;
        case (opcode)
            OP: begin
                aluOp      = mapAluOp(funct3, funct7 == F7_ALT);
                illegalDec = !(funct7 == F7_BASE ||
                               (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR)));
            end
            OP_IMM: begin
                selB  = SEL_B_IMM;
                aluOp = mapAluOp(funct3, funct3 == F3_SR && funct7[6:1] == F7_ALT[6:1]);
                case (funct3)                       // funct7[0] is shamt[5] here
                    F3_SLL:  illegalDec = funct7[6:1] != F7_BASE[6:1];
                    F3_SR:   illegalDec = funct7[6:1] != F7_BASE[6:1] &&
                                          funct7[6:1] != F7_ALT[6:1];
                    default: illegalDec = 1'b0;
                endcase
            end
            OP_32: begin
                word  = 1'b1;
                aluOp = mapAluOp(funct3, funct7 == F7_ALT);
                case (funct3)
                    F3_ADD, F3_SR: illegalDec = funct7 != F7_BASE && funct7 != F7_ALT;
                    F3_SLL:        illegalDec = funct7 != F7_BASE;
                    default:       illegalDec = 1'b1;
                endcase
            end
            OP_IMM_32: begin
                word  = 1'b1;
                selB  = SEL_B_IMM;
                aluOp = mapAluOp(funct3, funct3 == F3_SR && funct7 == F7_ALT);
                case (funct3)
                    F3_ADD:  illegalDec = 1'b0;
                    F3_SLL:  illegalDec = funct7 != F7_BASE;
                    F3_SR:   illegalDec = funct7 != F7_BASE && funct7 != F7_ALT;
                    default: illegalDec = 1'b1;
                endcase
            end
            LUI: begin
                selA  = SEL_A_ZERO;
                selB  = SEL_B_IMM;
                imm   = immU;
                aluOp = PASSB;
            end
            AUIPC: begin
                selA  = SEL_A_PC;
                selB  = SEL_B_IMM;
                imm   = immU;
                aluOp = ADD;
            end
            default: illegalDec = 1'b1;             // loads, branches, system, ...
        endcase
    end

    always_comb begin
        nextStage.valid             = instValid;
        nextStage.illegal           = instValid && illegalDec;
        nextStage.writeRd           = instValid && !illegalDec && rd != '0;
        nextStage.rd                = rd;
        nextStage.aluOp             = aluOp;
        nextStage.word              = word;
        nextStage.wordShiftSigned   = word && aluOp == SRA;
        nextStage.wordShiftUnsigned = word && aluOp == SRL;
        case (selA)
            SEL_A_PC:   nextStage.operandA = pc;
            SEL_A_ZERO: nextStage.operandA = '0;
            default:    nextStage.operandA = rs1Val;
        endcase
        nextStage.operandB = (selB == SEL_B_IMM) ? imm : rs2Val;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exStage <= '0;
        end else begin
            exStage <= nextStage;
        end
    end

    // an illegal op must never show up as a bypass source
    illegalNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        exFwd.illegal |-> !exFwd.valid);

endmodule

`default_nettype wire

//--- hw/aluStage.sv
`default_nettype none
`timescale 1ns/1ps

`include "rv_config.svh"

module aluStage (
    input  logic               clk,
    input  logic               arstN,
    input  rvCtrlPkg::decodedT exStage,
    output rvCtrlPkg::wbT      exFwd,
    output rvCtrlPkg::wbT      wb
);
    import rvCtrlPkg::*;

    localparam int SHAMT_W = $clog2(`RV_XLEN);     // 6 on RV64

    xlenT               opA;
    xlenT               opB;
    xlenT               rawRes;
    xlenT               result;
    logic [SHAMT_W-1:0] shamt;

    // word right shifts only see the low 32 bits of rs1
    always_comb begin
        opA = exStage.operandA;
        if (exStage.wordShiftSigned) begin
            opA = {{(`RV_XLEN-32){exStage.operandA[31]}}, exStage.operandA[31:0]};
        end else if (exStage.wordShiftUnsigned) begin
            opA = {{(`RV_XLEN-32){1'b0}}, exStage.operandA[31:0]};
        end
    end

    assign opB   = exStage.operandB;
    assign shamt = exStage.word ? {1'b0, opB[4:0]} : opB[SHAMT_W-1:0];

    always_comb begin
        case (exStage.aluOp)
            ADD:     rawRes = opA + opB;
            SUB:     rawRes = opA - opB;
            SLL:     rawRes = opA << shamt;
            SLT:     rawRes = xlenT'($signed(opA) < $signed(opB));
            SLTU:    rawRes = xlenT'(opA < opB);
            XOR:     rawRes = opA ^ opB;
            SRL:     rawRes = opA >> shamt;
            SRA:     rawRes = xlenT'($signed(opA) >>> shamt);
            OR:      rawRes = opA | opB;
            AND:     rawRes = opA & opB;
            PASSB:   rawRes = opB;
            default: rawRes = '0;
        endcase
    end

    assign result = exStage.word ? {{(`RV_XLEN-32){rawRes[31]}}, rawRes[31:0]} : rawRes;

    // same-cycle result, feeds decode bypass
    always_comb begin
        exFwd.valid   = exStage.valid && exStage.writeRd;
        exFwd.illegal = exStage.valid && exStage.illegal;
        exFwd.rd      = exStage.rd;
        exFwd.data    = result;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wb <= '0;
        end else begin
            wb <= exFwd;
        end
    end

    wordSignExt: assert property (@(posedge clk) disable iff (!arstN)
        exStage.valid && exStage.word && exStage.writeRd |=>
            wb.data[`RV_XLEN-1:31] == '0 || &wb.data[`RV_XLEN-1:31]);

endmodule

`default_nettype wire

//--- hw/intCore.sv
`default_nettype none
`timescale 1ns/1ps

module intCore (
    input  logic              clk,
    input  logic              arstN,
    input  logic              instValid,
    input  rvIsaPkg::instT    inst,
    input  rvCtrlPkg::xlenT   pc,
    output logic              wbValid,
    output rvIsaPkg::regAddrT wbRd,
    output rvCtrlPkg::xlenT   wbData,
    output logic              illegal
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    regAddrT rs1;
    regAddrT rs2;
    xlenT    rs1Data;
    xlenT    rs2Data;
    decodedT exStage;
    wbT      exFwd;
    wbT      wb;

    decodeStage uDecode (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .exFwd     (exFwd),
        .wbFwd     (wb),                            // second bypass source
        .exStage   (exStage)
    );

    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wb      (wb)
    );

    aluStage uAlu (
        .clk     (clk),
        .arstN   (arstN),
        .exStage (exStage),
        .exFwd   (exFwd),
        .wb      (wb)
    );

    assign wbValid = wb.valid;
    assign wbRd    = wb.rd;
    assign wbData  = wb.data;
    assign illegal = wb.illegal;

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`default_nettype none
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;                               // released away from the rising edge
    end

endmodule

`default_nettype wire

//--- tests/intCoreTb.sv
`default_nettype none
`timescale 1ns/1ps

module intCoreTb;
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    localparam int MAX_INSTS  = 700;
    localparam int MAX_CYCLES = 4 * MAX_INSTS + 200; // 3000

    // expected writeback of one issued slot
    typedef struct packed {
        logic    live;
        logic    write;
        logic    ill;
        regAddrT rd;
        xlenT    data;
    } expT;

    logic    clk;
    logic    arstN;
    logic    instValid;
    instT    inst;
    xlenT    pc;
    logic    wbValid;
    regAddrT wbRd;
    xlenT    wbData;
    logic    illegal;

    xlenT model [32];                               // mirror of the register file
    expT  pending [2];                              // [1] is the older slot
    int   cycles = 0;
    int   checks = 0;
    int   errors = 0;
    int   lastErrors = 0;
    int   tests = 0;

    clockGen uClk (.clk(clk), .arstN(arstN));

    intCore dut (
        .clk       (clk),
        .arstN     (arstN),
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData),
        .illegal   (illegal)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic checkData(string name, xlenT got, xlenT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkRd(string name, regAddrT got, regAddrT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // RV64I arithmetic from the ISA rules
    function automatic xlenT refAlu(funct3T f3, logic alt, xlenT a, xlenT b, logic word);
        logic [31:0] aw;
        logic [31:0] rw;
        xlenT        r;
        aw = a[31:0];
        if (word) begin
            case (f3)
                3'd0: rw = alt ? aw - b[31:0] : aw + b[31:0];
                3'd1: rw = aw << b[4:0];
                default: begin
                    if (alt)
                        rw = $signed(aw) >>> b[4:0];
                    else
                        rw = aw >> b[4:0];
                end
            endcase
            return {{32{rw[31]}}, rw};
        end
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[5:0];
            3'd2: r = {63'b0, $signed(a) < $signed(b)};
            3'd3: r = {63'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt)
                    r = $signed(a) >>> b[5:0];
                else
                    r = a >> b[5:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic expT commit(regAddrT rd, xlenT data);
        expT e;
        e.live  = 1'b1;
        e.write = rd != '0;                         // x0 never shows a writeback
        e.ill   = 1'b0;
        e.rd    = rd;
        e.data  = data;
        if (rd != '0) begin
            model[rd] = data;
        end
        return e;
    endfunction

    // check the slot issued two cycles ago, then drive the next one
    task automatic step(logic v, instT i, xlenT p, expT e);
        @(negedge clk);
        checkFlag("wbValid", wbValid, pending[1].live && pending[1].write);
        checkFlag("illegal", illegal, pending[1].live && pending[1].ill);
        if (pending[1].live && pending[1].write) begin
            checkRd("wbRd", wbRd, pending[1].rd);
            checkData("wbData", wbData, pending[1].data);
        end
        pending[1] = pending[0];
        pending[0] = e;
        instValid  = v;
        inst       = i;
        pc         = p;
    endtask

    task automatic idle();
        step(1'b0, '0, '0, '0);
    endtask

    task automatic sendRR(logic alt, funct3T f3, regAddrT rd, regAddrT rs1, regAddrT rs2,
                          logic word);
        logic [6:0] opc;
        opc = word ? OP_32 : OP;
        step(1'b1, {alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd, opc}, '0,
             commit(rd, refAlu(f3, alt, model[rs1], model[rs2], word)));
    endtask

    task automatic sendRI(funct3T f3, regAddrT rd, regAddrT rs1, logic [11:0] imm, logic word);
        logic [6:0] opc;
        logic       alt;
        opc = word ? OP_IMM_32 : OP_IMM;
        alt = f3 == 3'd5 && imm[10];                // srai / sraiw
        step(1'b1, {imm, rs1, f3, rd, opc}, '0,
             commit(rd, refAlu(f3, alt, model[rs1], {{52{imm[11]}}, imm}, word)));
    endtask

    task automatic sendU(logic isAuipc, regAddrT rd, logic [19:0] imm, xlenT p);
        xlenT uImm;
        uImm = {{32{imm[19]}}, imm, 12'b0};
        step(1'b1, {imm, rd, isAuipc ? AUIPC : LUI}, p,
             commit(rd, isAuipc ? p + uImm : uImm));
    endtask

    task automatic sendBad(instT i);
        expT e;
        e      = '0;
        e.live = 1'b1;
        e.ill  = 1'b1;
        step(1'b1, i, '0, e);
    endtask

    // random 64-bit value built from two lui/addi pairs, x31 as scratch
    task automatic loadRand(regAddrT rd);
        sendU(1'b0, rd, 20'($urandom), '0);
        sendRI(3'd0, rd, rd, 12'($urandom), 1'b0);
        sendRI(3'd1, rd, rd, 12'd32, 1'b0);
        sendU(1'b0, 5'd31, 20'($urandom), '0);
        sendRI(3'd0, 5'd31, 5'd31, 12'($urandom), 1'b0);
        sendRR(1'b0, 3'd4, rd, rd, 5'd31, 1'b0);
    endtask

    task automatic finishTest(string name);
        idle();
        idle();
        tests++;
        $display("%-12s %0d errors", name, errors - lastErrors);
        lastErrors = errors;
    endtask

    task automatic resetTest();
        idle();
        idle();
        for (int r = 0; r < 32; r++) begin
            sendRI(3'd0, 5'd1, 5'(r), 12'd0, 1'b0);
        end
        finishTest("reset");
    endtask

    task automatic regRegTest();
        for (int k = 0; k < 8; k++) begin
            loadRand(5'd1);
            loadRand(5'd2);
            for (int f = 0; f < 8; f++) begin
                sendRR(1'b0, funct3T'(f), 5'(10 + f), 5'd1, 5'd2, 1'b0);
            end
            sendRR(1'b1, 3'd0, 5'd18, 5'd1, 5'd2, 1'b0);     // sub
            sendRR(1'b1, 3'd5, 5'd19, 5'd1, 5'd2, 1'b0);     // sra
        end
        finishTest("regReg");
    endtask

    task automatic regImmTest();
        for (int k = 0; k < 8; k++) begin
            loadRand(5'd3);
            sendRI(3'd0, 5'd4, 5'd3, 12'($urandom), 1'b0);
            sendRI(3'd2, 5'd5, 5'd3, {1'b1, 11'($urandom)}, 1'b0);
            sendRI(3'd3, 5'd6, 5'd3, {1'b1, 11'($urandom)}, 1'b0);
            sendRI(3'd4, 5'd7, 5'd3, 12'($urandom), 1'b0);
            sendRI(3'd6, 5'd8, 5'd3, 12'($urandom), 1'b0);
            sendRI(3'd7, 5'd9, 5'd3, 12'($urandom), 1'b0);
            sendRI(3'd1, 5'd10, 5'd3, {6'b000000, 6'($urandom)}, 1'b0);
            sendRI(3'd5, 5'd11, 5'd3, {6'b000000, 6'($urandom)}, 1'b0);
            sendRI(3'd5, 5'd12, 5'd3, {6'b010000, 6'($urandom)}, 1'b0);
        end
        finishTest("regImm");
    endtask

    task automatic wordTest();
        for (int k = 0; k < 6; k++) begin
            loadRand(5'd13);
            loadRand(5'd14);
            sendRR(1'b0, 3'd0, 5'd15, 5'd13, 5'd14, 1'b1);   // addw
            sendRR(1'b1, 3'd0, 5'd16, 5'd13, 5'd14, 1'b1);   // subw
            sendRR(1'b0, 3'd1, 5'd17, 5'd13, 5'd14, 1'b1);
            sendRR(1'b0, 3'd5, 5'd18, 5'd13, 5'd14, 1'b1);
            sendRR(1'b1, 3'd5, 5'd19, 5'd13, 5'd14, 1'b1);
            sendRI(3'd0, 5'd20, 5'd13, 12'($urandom), 1'b1);
            sendRI(3'd1, 5'd21, 5'd13, {7'b0000000, 5'($urandom)}, 1'b1);
            sendRI(3'd5, 5'd22, 5'd13, {7'b0000000, 5'($urandom)}, 1'b1);
            sendRI(3'd5, 5'd23, 5'd13, {7'b0100000, 5'($urandom)}, 1'b1);
        end
        finishTest("word");
    endtask

    task automatic upperTest();
        for (int k = 0; k < 8; k++) begin
            sendU(1'b0, 5'(24 + k % 4), 20'($urandom), '0);
            sendU(1'b1, 5'(24 + k % 4), 20'($urandom), {$urandom, $urandom});
        end
        finishTest("luiAuipc");
    endtask

    task automatic hazardTest();
        sendRI(3'd0, 5'd5, 5'd0, 12'($urandom), 1'b0);
        sendRR(1'b0, 3'd0, 5'd6, 5'd5, 5'd5, 1'b0);          // x5 from execute
        sendRR(1'b0, 3'd0, 5'd7, 5'd5, 5'd6, 1'b0);          // x5 from wb, x6 from execute
        sendRR(1'b1, 3'd0, 5'd7, 5'd7, 5'd6, 1'b0);
        sendRI(3'd1, 5'd7, 5'd7, 12'd3, 1'b0);
        sendRR(1'b0, 3'd0, 5'd0, 5'd6, 5'd7, 1'b0);          // rd 0, no writeback
        sendRR(1'b0, 3'd0, 5'd8, 5'd0, 5'd7, 1'b0);
        sendBad({12'd0, 5'd1, 3'b011, 5'd2, 7'b0000011});      // ld
        sendBad({7'd0, 5'd2, 5'd1, 3'b000, 5'd0, 7'b1100011}); // beq
        sendBad({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011}); // mul
        sendRR(1'b0, 3'd6, 5'd9, 5'd8, 5'd3, 1'b0);
        finishTest("hazard");
    endtask

    initial begin
        instValid = 1'b0;
        inst      = '0;
        pc        = '0;
        pending[0] = '0;
        pending[1] = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        void'($urandom(32'he2b));
        @(posedge arstN);
        resetTest();
        regRegTest();
        regImmTest();
        wordTest();
        upperTest();
        hazardTest();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/rvIsaPkg.sv
hw/rvCtrlPkg.sv
hw/regFile.sv
hw/decodeStage.sv
hw/aluStage.sv
hw/intCore.sv
tests/clockGen.sv
tests/intCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= intCoreTb
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
